// File: l2_cache.f
design/l2_defines.sv
design/l2_queue.sv
design/l2_cache_arb_stage.sv
design/l2_cache_tag_stage.sv
design/l2_cache_read_stage.sv
design/l2_cache_update_stage.sv
design/l2_bus_interface.sv
design/l2_cache.sv
verification/l2_cache_tb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = l2_cache_tb
RTL_TOP    = l2_cache
FILELIST   = l2_cache.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
BUILD_DIR  = obj_dir
PASS_TEXT  = *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	@out=$$(./$(BUILD_DIR)/$(TOP)); echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: verification/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;

  localparam int NUM_CORES         = 2;
  localparam int LINES             = 48;                // Three times the cache capacity
  localparam int DIRECTED_REQUESTS = 10;
  localparam int RANDOM_PER_CORE   = 40;
  localparam int STALL_PER_CORE    = 20;
  localparam int PLANNED_REQUESTS  = DIRECTED_REQUESTS +
                                     NUM_CORES * (RANDOM_PER_CORE + STALL_PER_CORE);

  logic                     clk;
  logic                     rst;
  logic [NUM_CORES-1:0]     request_valid;
  l2_defines::l2_request_t  request [NUM_CORES];
  logic [NUM_CORES-1:0]     ready;
  logic                     response_valid;
  l2_defines::l2_response_t response;
  logic                     mem_request_valid;
  l2_defines::mem_request_t mem_request;
  logic                     mem_ready;
  logic                     mem_response_valid;
  l2_defines::line_data_t   mem_response_data;

  l2_defines::line_data_t  mem_lines [64];              // System memory, one entry per line
  logic [31:0]             shadow [l2_defines::l2_addr_t];  // Last store per word
  l2_defines::l2_request_t pending [NUM_CORES];         // Outstanding request per core
  bit                      busy [NUM_CORES];
  int                      accept_cycle [NUM_CORES];
  int                      last_latency [NUM_CORES];
  int                      cycle_count;
  int                      issued;
  int                      responses;
  int                      mem_reads;
  int                      ready_drops;
  int                      hold_count;
  int                      read_delay;
  int                      response_errors;
  int                      writeback_errors;
  int                      value_errors;
  logic                    read_busy;                   // Memory read in flight
  logic                    stall_phase;
  logic                    ready_low;                   // All ready bits low last cycle
  l2_defines::l2_addr_t    read_addr;
  string                   test_name;

  l2_cache #(.NUM_CORES(NUM_CORES), .L2_SETS(8), .QUEUE_DEPTH(4)) u_dut (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] init_word(input l2_defines::l2_addr_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a0f_c3e1;  // All bits mix
  endfunction

  function automatic logic [31:0] expected_load(input l2_defines::l2_addr_t addr);
    if (shadow.exists(addr)) return shadow[addr];
    return init_word(addr);                             // Never stored
  endfunction

  function automatic l2_defines::line_data_t expected_line(input l2_defines::l2_addr_t addr);
    l2_defines::line_data_t line;
    for (int w = 0; w < l2_defines::WORDS_PER_LINE; w++) begin
      line[w*32 +: 32] = expected_load(addr + 32'(w * 4));  // Word 0 in low bits
    end
    return line;
  endfunction

  task automatic check_response(input string name, input l2_defines::l2_response_t expected,
                                input l2_defines::l2_response_t actual);
    string exp_text;
    string act_text;
    if (actual !== expected) begin
      response_errors++;
      exp_text = $sformatf("core %0d store %0b addr %h data %h", expected.core,
                           expected.store, expected.address, expected.data);
      act_text = $sformatf("core %0d store %0b addr %h data %h", actual.core,
                           actual.store, actual.address, actual.data);
      $display("Fail %s: expected %s, actual %s", name, exp_text, act_text);
    end
  endtask

  task automatic check_writeback(input string name, input l2_defines::mem_request_t expected,
                                 input l2_defines::mem_request_t actual);
    if (actual !== expected) begin
      writeback_errors++;
      $display("Fail %s: addr %h expected %h, actual %h", name, actual.address,
               expected.data, actual.data);
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (actual != expected) begin
      value_errors++;
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic send(input int c, input logic store, input l2_defines::l2_addr_t addr,
                      input logic [31:0] data);
    @(negedge clk);
    while (busy[c]) @(negedge clk);                     // One outstanding per core
    request_valid[c]   = 1'b1;
    request[c].store   = store;
    request[c].address = addr;
    request[c].data    = data;
    request[c].core    = '0;                            // Arbiter stamps it
    @(posedge clk);
    while (!ready[c]) @(posedge clk);                   // Accept edge
    pending[c]      = request[c];
    accept_cycle[c] = cycle_count;
    busy[c]         = 1'b1;
    issued++;
    @(negedge clk);
    request_valid[c] = 1'b0;
  endtask

  task automatic wait_done(input int c);
    while (busy[c]) @(negedge clk);
  endtask

  task automatic random_traffic(input int c, input int count);
    int line;
    int word;
    for (int i = 0; i < count; i++) begin
      line = int'($urandom_range(LINES - 1, 0));
      word = 2 * c + int'($urandom_range(1, 0));        // Core 0 owns words 0 and 1
      send(c, 1'($urandom_range(1, 0)), 32'(line * 16 + word * 4), $urandom);
    end
    wait_done(c);
  endtask

  always @(posedge clk) begin : compare_responses
    l2_defines::l2_response_t expected;
    int c;
    if (!rst && response_valid) begin
      c = int'(response.address[3]);                    // Words 2 and 3 belong to core 1
      if (!busy[c]) begin
        value_errors++;
        $display("Error: response for core %0d, which has no request outstanding", c);
      end else begin
        expected.core    = l2_defines::core_id_t'(c);
        expected.store   = pending[c].store;
        expected.address = pending[c].address;
        expected.data    = pending[c].store ? 32'h0 : expected_load(pending[c].address);
        check_response(test_name, expected, response);
        if (pending[c].store) shadow[pending[c].address] = pending[c].data;  // Now visible
        last_latency[c] = cycle_count - accept_cycle[c];
        responses++;
        busy[c] = 1'b0;
      end
    end
  end

  always @(posedge clk) begin : memory_accept
    l2_defines::mem_request_t expected;
    if (!rst && stall_phase && ready == '0) begin
      if (ready_low) ready_drops++;                     // Held off longer than a restart
      ready_low = 1'b1;
    end else begin
      ready_low = 1'b0;
    end
    if (!rst && mem_request_valid && mem_ready) begin
      if (mem_request.address >= 32'(LINES * 16) || mem_request.address[3:0] != 4'h0) begin
        value_errors++;
        $display("Error: memory request to %h is outside the test range or not line aligned",
                 mem_request.address);
      end else if (mem_request.write) begin
        expected.write   = 1'b1;
        expected.address = mem_request.address;
        expected.data    = expected_line(mem_request.address);
        check_writeback({test_name, " writeback"}, expected, mem_request);
        mem_lines[mem_request.address[9:4]] = mem_request.data;
      end else begin
        mem_reads++;
        read_addr  = mem_request.address;
        read_delay = int'($urandom_range(8, 1));        // Random read latency
        read_busy  = 1'b1;
      end
    end
  end

  always @(negedge clk) begin : memory_drive
    cycle_count++;
    hold_count++;
    mem_response_valid = 1'b0;
    if (read_busy) begin
      if (read_delay == 0) begin
        mem_response_valid = 1'b1;                      // One-cycle pulse
        mem_response_data  = mem_lines[read_addr[9:4]];
        read_busy          = 1'b0;
      end else begin
        read_delay--;
      end
    end
    mem_ready = !(stall_phase && (hold_count % 160) < 120) && ($urandom_range(3, 0) != 0);
  end

  initial begin : watchdog
    repeat (200 * PLANNED_REQUESTS + 2000) @(posedge clk);
    $display("Error: timeout, only %0d of %0d issued requests answered", responses, issued);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main_sequence
    int reads_before;
    void'($urandom(32'h07169e2b));
    clk                = 1'b0;
    rst                = 1'b1;
    request_valid      = '0;
    mem_ready          = 1'b0;
    mem_response_valid = 1'b0;
    mem_response_data  = '0;
    read_busy          = 1'b0;
    stall_phase        = 1'b0;
    ready_low          = 1'b0;
    test_name          = "reset";
    for (int c = 0; c < NUM_CORES; c++) request[c] = '0;
    for (int i = 0; i < 64; i++) begin
      for (int w = 0; w < 4; w++) mem_lines[i][w*32 +: 32] = init_word(32'(i * 16 + w * 4));
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    check_value("reset response_valid", 0, int'(response_valid));
    check_value("reset mem_request_valid", 0, int'(mem_request_valid));
    check_value("reset ready", (1 << NUM_CORES) - 1, int'(ready));

    test_name    = "cold load";
    reads_before = mem_reads;
    send(0, 1'b0, 32'h0000_0100, 32'h0);
    wait_done(0);
    check_value("cold load memory reads", reads_before + 1, mem_reads);
    test_name    = "hit load";
    reads_before = mem_reads;
    send(0, 1'b0, 32'h0000_0104, 32'h0);
    wait_done(0);
    check_value("hit load latency", 4, last_latency[0]);  // Accept edge to response
    check_value("hit load memory reads", reads_before, mem_reads);

    test_name = "store then load";
    send(0, 1'b1, 32'h0000_0104, 32'hcafe_0104);
    send(0, 1'b0, 32'h0000_0104, 32'h0);
    wait_done(0);
    test_name = "shared line miss";
    fork
      send(0, 1'b0, 32'h0000_0200, 32'h0);
      send(1, 1'b0, 32'h0000_0208, 32'h0);
    join
    wait_done(0);
    wait_done(1);
    test_name = "shared line stores";
    fork
      begin
        send(0, 1'b1, 32'h0000_0244, $urandom);
        send(0, 1'b0, 32'h0000_0244, 32'h0);
      end
      begin
        send(1, 1'b1, 32'h0000_024c, $urandom);
        send(1, 1'b0, 32'h0000_024c, 32'h0);
      end
    join
    wait_done(0);
    wait_done(1);

    test_name = "random traffic";
    fork
      random_traffic(0, RANDOM_PER_CORE);
      random_traffic(1, RANDOM_PER_CORE);
    join

    test_name   = "memory stall";
    ready_drops = 0;
    stall_phase = 1'b1;                                 // Long stretches of mem_ready low
    fork
      random_traffic(0, STALL_PER_CORE);
      random_traffic(1, STALL_PER_CORE);
    join
    stall_phase = 1'b0;
    check_value("memory stall ready drops", 1, int'(ready_drops > 0));
    check_value("responses for issued requests", issued, responses);

    $display("Result: %0d response errors, %0d writeback errors, %0d other errors",
             response_errors, writeback_errors, value_errors);
    if (response_errors + writeback_errors + value_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: design/l2_cache.sv
`timescale 1ns/1ps

module l2_cache #(
  parameter int  NUM_CORES   = 2,
  parameter int  L2_SETS     = 8,
  parameter int  QUEUE_DEPTH = 4,
  localparam int OFFSET_BITS = $clog2(l2_defines::WORDS_PER_LINE) + 2,
  localparam int SET_BITS    = $clog2(L2_SETS),
  localparam int TAG_BITS    = 32 - SET_BITS - OFFSET_BITS,
  localparam int INDEX_BITS  = SET_BITS + 1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [NUM_CORES-1:0]     request_valid,
  input  l2_defines::l2_request_t  request [NUM_CORES],
  output logic [NUM_CORES-1:0]     ready,
  output logic                     response_valid,
  output l2_defines::l2_response_t response,
  output logic                     mem_request_valid,
  output l2_defines::mem_request_t mem_request,
  input  logic                     mem_ready,
  input  logic                     mem_response_valid,
  input  l2_defines::line_data_t   mem_response_data
);

  logic                    arb_valid;                   // Arbiter to tag stage
  l2_defines::l2_request_t arb_request;
  logic                    arb_fill;
  l2_defines::line_data_t  arb_data;
  logic                    tag_valid;                   // Tag stage to read stage
  l2_defines::l2_request_t tag_request;
  logic                    tag_fill;
  l2_defines::line_data_t  tag_data;
  logic [l2_defines::L2_WAYS-1:0][TAG_BITS-1:0] way_tag;
  logic [l2_defines::L2_WAYS-1:0] way_valid;
  logic [l2_defines::L2_WAYS-1:0] way_dirty;
  logic                    lru_way;
  logic                    tag_update_en;               // Read stage back to tag arrays
  logic [SET_BITS-1:0]     update_set;
  logic                    update_way;
  logic [TAG_BITS-1:0]     update_tag;
  logic                    update_valid;
  logic                    dirty_update_en;
  logic                    dirty_value;
  logic                    lru_update_en;
  logic                    lru_hit_way;
  logic                    fill_push;                   // Read stage to bus queues
  l2_defines::fill_entry_t fill_entry;
  logic                    writeback_push;
  l2_defines::writeback_entry_t writeback_entry;
  logic                    read_valid;                  // Read stage to update stage
  l2_defines::l2_request_t read_request;
  l2_defines::line_data_t  read_line;
  logic [INDEX_BITS-1:0]   read_index;
  logic                    write_en;                    // Update stage data write
  logic [INDEX_BITS-1:0]   write_index;
  l2_defines::line_data_t  write_line;
  logic                    restart_valid;               // Bus interface to arbiter
  l2_defines::l2_request_t restart_request;
  l2_defines::line_data_t  restart_data;
  logic                    bus_stall;

  l2_cache_arb_stage #(.NUM_CORES(NUM_CORES)) u_arb_stage (.*);
  l2_cache_tag_stage #(.L2_SETS(L2_SETS)) u_tag_stage (.*);
  l2_cache_read_stage #(.L2_SETS(L2_SETS)) u_read_stage (.*);
  l2_cache_update_stage #(.L2_SETS(L2_SETS)) u_update_stage (.*);

  l2_bus_interface #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_bus_interface (
    .*,
    .restart_ready(1'b1));                              // Arbiter always takes a restart

endmodule

// File: design/l2_bus_interface.sv
`timescale 1ns/1ps

module l2_bus_interface #(
  parameter int  QUEUE_DEPTH = 4,
  localparam int COUNT_BITS  = $clog2(QUEUE_DEPTH + 1),
  localparam int OFFSET_BITS = $clog2(l2_defines::WORDS_PER_LINE) + 2
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         fill_push,
  input  l2_defines::fill_entry_t      fill_entry,
  input  logic                         writeback_push,
  input  l2_defines::writeback_entry_t writeback_entry,
  output logic                         mem_request_valid,
  output l2_defines::mem_request_t     mem_request,
  input  logic                         mem_ready,
  input  logic                         mem_response_valid,
  input  l2_defines::line_data_t       mem_response_data,
  output logic                         restart_valid,
  output l2_defines::l2_request_t      restart_request,
  output l2_defines::line_data_t       restart_data,
  input  logic                         restart_ready,
  output logic                         bus_stall
);

  typedef enum logic [2:0] {IDLE, WRITE, READ, WAIT, RESTART} state_t;

  state_t                       state;
  l2_defines::fill_entry_t      fill_head;
  l2_defines::writeback_entry_t writeback_head;
  logic                         fill_empty;
  logic                         writeback_empty;
  logic                         fill_pop;
  logic                         writeback_pop;
  logic [COUNT_BITS-1:0]        fill_free;
  logic [1:0]                   drain_count;            // Restart still ahead of read stage
  l2_defines::line_data_t       fill_line;              // Line returned by memory

  l2_queue #(.T(l2_defines::fill_entry_t), .DEPTH(QUEUE_DEPTH)) u_fill_queue (
    .clk, .rst, .push(fill_push), .push_data(fill_entry), .pop(fill_pop),
    .pop_data(fill_head), .empty(fill_empty), .free_count(fill_free));

  l2_queue #(.T(l2_defines::writeback_entry_t), .DEPTH(QUEUE_DEPTH)) u_writeback_queue (
    .clk, .rst, .push(writeback_push), .push_data(writeback_entry), .pop(writeback_pop),
    .pop_data(writeback_head), .empty(writeback_empty), .free_count());

  assign bus_stall     = fill_free < COUNT_BITS'(3);    // Room for three requests in flight
  assign fill_pop      = (state == RESTART) && restart_ready;
  assign writeback_pop = (state == WRITE) && mem_ready;

  assign mem_request_valid = (state == WRITE) || (state == READ);
  always_comb begin
    mem_request.write   = (state == WRITE);
    mem_request.address = (state == WRITE) ? writeback_head.address :
                          {fill_head.address[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    mem_request.data    = writeback_head.data;
  end

  assign restart_valid   = (state == RESTART);
  assign restart_request = fill_head;                   // Head stays until the pop
  assign restart_data    = fill_line;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      drain_count <= '0;
    end else begin
      if (drain_count != '0) drain_count <= drain_count - 1'b1;
      case (state)
        IDLE: begin
          if (!writeback_empty) state <= WRITE;         // Evicted data goes out first
          else if (!fill_empty && drain_count == '0) state <= READ;
        end
        WRITE:   if (mem_ready) state <= IDLE;
        READ:    if (mem_ready) state <= WAIT;
        WAIT:    if (mem_response_valid) state <= RESTART;
        RESTART: begin
          if (restart_ready) begin
            state       <= IDLE;
            drain_count <= 2'd2;                        // Its writeback lands two edges on
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mem_response_valid) fill_line <= mem_response_data;
  end

endmodule

// File: design/l2_cache_update_stage.sv
`timescale 1ns/1ps

module l2_cache_update_stage #(
  parameter int  L2_SETS    = 8,
  localparam int INDEX_BITS = $clog2(L2_SETS) + 1,
  localparam int WORD_BITS  = $clog2(l2_defines::WORDS_PER_LINE)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     read_valid,
  input  l2_defines::l2_request_t  read_request,
  input  l2_defines::line_data_t   read_line,
  input  logic [INDEX_BITS-1:0]    read_index,
  output logic                     write_en,
  output logic [INDEX_BITS-1:0]    write_index,
  output l2_defines::line_data_t   write_line,
  output logic                     response_valid,
  output l2_defines::l2_response_t response
);

  logic [WORD_BITS-1:0] word_sel;                       // Word within the line

  assign word_sel = read_request.address[2 +: WORD_BITS];

  always_comb begin
    write_line = read_line;
    if (read_request.store) write_line[word_sel*32 +: 32] = read_request.data;  // Merge word
  end

  assign write_en    = read_valid;                      // Loads rewrite the unchanged line
  assign write_index = read_index;

  always_ff @(posedge clk) begin
    if (rst) begin
      response_valid <= 1'b0;
    end else begin
      response_valid <= read_valid;                     // One-cycle pulse per request
    end
  end

  always_ff @(posedge clk) begin
    response.core    <= read_request.core;
    response.store   <= read_request.store;
    response.address <= read_request.address;
    response.data    <= read_request.store ? 32'h0 : read_line[word_sel*32 +: 32];
  end

endmodule

// File: design/l2_cache_read_stage.sv
`timescale 1ns/1ps

module l2_cache_read_stage #(
  parameter int  L2_SETS     = 8,
  localparam int OFFSET_BITS = $clog2(l2_defines::WORDS_PER_LINE) + 2,
  localparam int SET_BITS    = $clog2(L2_SETS),
  localparam int TAG_BITS    = 32 - SET_BITS - OFFSET_BITS,
  localparam int INDEX_BITS  = SET_BITS + 1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    tag_valid,
  input  l2_defines::l2_request_t tag_request,
  input  logic                    tag_fill,
  input  l2_defines::line_data_t  tag_data,
  input  logic [l2_defines::L2_WAYS-1:0][TAG_BITS-1:0] way_tag,
  input  logic [l2_defines::L2_WAYS-1:0] way_valid,
  input  logic [l2_defines::L2_WAYS-1:0] way_dirty,
  input  logic                    lru_way,
  input  logic                    write_en,
  input  logic [INDEX_BITS-1:0]   write_index,
  input  l2_defines::line_data_t  write_line,
  output logic                    tag_update_en,
  output logic [SET_BITS-1:0]     update_set,
  output logic                    update_way,
  output logic [TAG_BITS-1:0]     update_tag,
  output logic                    update_valid,
  output logic                    dirty_update_en,
  output logic                    dirty_value,
  output logic                    lru_update_en,
  output logic                    lru_hit_way,
  output logic                    fill_push,
  output l2_defines::fill_entry_t fill_entry,
  output logic                    writeback_push,
  output l2_defines::writeback_entry_t writeback_entry,
  output logic                    read_valid,
  output l2_defines::l2_request_t read_request,
  output l2_defines::line_data_t  read_line,
  output logic [INDEX_BITS-1:0]   read_index
);

  l2_defines::line_data_t data_array [l2_defines::L2_WAYS*L2_SETS];  // Indexed {way, set}
  logic [SET_BITS-1:0]    req_set;
  logic [TAG_BITS-1:0]    req_tag;
  logic [l2_defines::L2_WAYS-1:0] hit_vec;
  logic                   hit;
  logic                   install;                      // Fill takes over the LRU way
  logic                   proceed;                      // Request continues to update
  logic                   access_way;
  logic [INDEX_BITS-1:0]  access_index;
  l2_defines::line_data_t access_line;

  assign req_set = tag_request.address[OFFSET_BITS +: SET_BITS];
  assign req_tag = tag_request.address[31 -: TAG_BITS];

  always_comb begin
    for (int w = 0; w < l2_defines::L2_WAYS; w++) begin
      hit_vec[w] = way_valid[w] && (way_tag[w] == req_tag);
    end
  end

  assign hit          = |hit_vec;                       // Duplicate fills land here too
  assign install      = tag_valid && tag_fill && !hit;
  assign proceed      = tag_valid && (hit || tag_fill);
  assign access_way   = hit ? hit_vec[1] : lru_way;     // Victim way on a miss
  assign access_index = {access_way, req_set};
  assign access_line  = (write_en && write_index == access_index) ?
                        write_line : data_array[access_index];  // Bypass from update stage

  assign tag_update_en   = install;
  assign update_set      = req_set;
  assign update_way      = access_way;
  assign update_tag      = req_tag;
  assign update_valid    = 1'b1;                        // Installs only, no invalidation
  assign dirty_update_en = install || (proceed && tag_request.store);
  assign dirty_value     = tag_request.store;           // Install clears unless a store
  assign lru_update_en   = proceed;
  assign lru_hit_way     = access_way;

  assign fill_push  = tag_valid && !tag_fill && !hit;   // Miss leaves the pipeline
  assign fill_entry = tag_request;

  assign writeback_push = install && way_valid[lru_way] && way_dirty[lru_way];
  always_comb begin
    writeback_entry.address = {way_tag[lru_way], req_set, {OFFSET_BITS{1'b0}}};
    writeback_entry.data    = access_line;              // Old victim contents
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      read_valid <= 1'b0;
    end else begin
      read_valid <= proceed;
    end
  end

  always_ff @(posedge clk) begin
    read_request <= tag_request;
    read_index   <= access_index;
    read_line    <= install ? tag_data : access_line;   // New line from memory
    if (write_en) data_array[write_index] <= write_line;
  end

endmodule

// File: design/l2_cache_tag_stage.sv
`timescale 1ns/1ps

module l2_cache_tag_stage #(
  parameter int  L2_SETS     = 8,
  localparam int OFFSET_BITS = $clog2(l2_defines::WORDS_PER_LINE) + 2,
  localparam int SET_BITS    = $clog2(L2_SETS),
  localparam int TAG_BITS    = 32 - SET_BITS - OFFSET_BITS
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    arb_valid,
  input  l2_defines::l2_request_t arb_request,
  input  logic                    arb_fill,
  input  l2_defines::line_data_t  arb_data,
  input  logic                    tag_update_en,
  input  logic [SET_BITS-1:0]     update_set,
  input  logic                    update_way,
  input  logic [TAG_BITS-1:0]     update_tag,
  input  logic                    update_valid,
  input  logic                    dirty_update_en,
  input  logic                    dirty_value,
  input  logic                    lru_update_en,
  input  logic                    lru_hit_way,
  output logic                    tag_valid,
  output l2_defines::l2_request_t tag_request,
  output logic                    tag_fill,
  output l2_defines::line_data_t  tag_data,
  output logic [l2_defines::L2_WAYS-1:0][TAG_BITS-1:0] way_tag,
  output logic [l2_defines::L2_WAYS-1:0] way_valid,
  output logic [l2_defines::L2_WAYS-1:0] way_dirty,
  output logic                    lru_way
);

  logic [TAG_BITS-1:0] tag_array [L2_SETS][l2_defines::L2_WAYS];
  logic [L2_SETS-1:0][l2_defines::L2_WAYS-1:0] valid_bits;
  logic [L2_SETS-1:0][l2_defines::L2_WAYS-1:0] dirty_bits;
  logic [L2_SETS-1:0]  lru_bits;                        // Way to replace next
  logic [SET_BITS-1:0] tag_set;                         // Set of the held request

  assign tag_set = tag_request.address[OFFSET_BITS +: SET_BITS];

  always_comb begin
    for (int w = 0; w < l2_defines::L2_WAYS; w++) begin
      way_tag[w] = tag_array[tag_set][w];               // Last edge's update already in
    end
  end

  assign way_valid = valid_bits[tag_set];
  assign way_dirty = dirty_bits[tag_set];
  assign lru_way   = lru_bits[tag_set];

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_valid  <= 1'b0;
      tag_fill   <= 1'b0;
      valid_bits <= '0;                                 // All lines invalid
      dirty_bits <= '0;
      lru_bits   <= '0;
    end else begin
      tag_valid <= arb_valid;
      tag_fill  <= arb_fill;
      if (tag_update_en) valid_bits[update_set][update_way] <= update_valid;
      if (dirty_update_en) dirty_bits[update_set][update_way] <= dirty_value;
      if (lru_update_en) lru_bits[update_set] <= ~lru_hit_way;  // Other way is now older
    end
  end

  always_ff @(posedge clk) begin
    tag_request <= arb_request;
    tag_data    <= arb_data;
    if (tag_update_en) tag_array[update_set][update_way] <= update_tag;
  end

endmodule

// File: design/l2_cache_arb_stage.sv
`timescale 1ns/1ps

module l2_cache_arb_stage #(
  parameter int  NUM_CORES = 2,
  localparam int CORE_BITS = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [NUM_CORES-1:0]    request_valid,
  input  l2_defines::l2_request_t request [NUM_CORES],
  output logic [NUM_CORES-1:0]    ready,
  input  logic                    restart_valid,
  input  l2_defines::l2_request_t restart_request,
  input  l2_defines::line_data_t  restart_data,
  input  logic                    bus_stall,
  output logic                    arb_valid,
  output l2_defines::l2_request_t arb_request,
  output logic                    arb_fill,
  output l2_defines::line_data_t  arb_data
);

  logic [CORE_BITS-1:0] last_grant;                     // Round-robin pointer
  logic [CORE_BITS-1:0] grant_idx;
  logic                 grant_found;
  logic                 core_open;                      // Cores may be taken this cycle

  assign core_open = !restart_valid && !bus_stall;      // Restart wins, stall blocks cores

  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_idx   = last_grant;
    for (int i = 1; i <= NUM_CORES; i++) begin          // Search starts after last winner
      idx = (int'(last_grant) + i) % NUM_CORES;
      if (!grant_found && request_valid[idx]) begin
        grant_found = 1'b1;
        grant_idx   = CORE_BITS'(idx);
      end
    end
  end

  always_comb begin
    for (int c = 0; c < NUM_CORES; c++) begin
      ready[c] = core_open && (!request_valid[c] || grant_idx == CORE_BITS'(c));  // Losers wait
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      arb_valid  <= 1'b0;
      arb_fill   <= 1'b0;
      last_grant <= CORE_BITS'(NUM_CORES - 1);          // Core 0 goes first
    end else begin
      arb_valid <= restart_valid || (core_open && grant_found);
      arb_fill  <= restart_valid;
      if (core_open && grant_found) last_grant <= grant_idx;
    end
  end

  always_ff @(posedge clk) begin
    arb_data <= restart_data;                           // Used only with arb_fill
    if (restart_valid) begin
      arb_request <= restart_request;                   // Core id kept from first pass
    end else begin
      arb_request      <= request[grant_idx];
      arb_request.core <= l2_defines::core_id_t'(grant_idx);
    end
  end

endmodule

// File: design/l2_queue.sv
`timescale 1ns/1ps

module l2_queue #(
  parameter type T           = logic,
  parameter int  DEPTH       = 4,
  localparam int PTR_BITS    = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int COUNT_BITS  = $clog2(DEPTH + 1)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  T                      push_data,
  input  logic                  pop,
  output T                      pop_data,
  output logic                  empty,
  output logic [COUNT_BITS-1:0] free_count
);

  T                      storage [DEPTH];               // Circular buffer
  logic [PTR_BITS-1:0]   read_ptr;
  logic [PTR_BITS-1:0]   write_ptr;
  logic [COUNT_BITS-1:0] count;                         // Occupied entries

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // Wraps for any depth
  endfunction

  assign pop_data   = storage[read_ptr];                // Head shown ahead of pop
  assign empty      = (count == '0);
  assign free_count = COUNT_BITS'(DEPTH) - count;

  always_ff @(posedge clk) begin
    if (rst) begin
      read_ptr  <= '0;
      write_ptr <= '0;
      count     <= '0;
    end else begin
      if (push) write_ptr <= next_ptr(write_ptr);
      if (pop) read_ptr <= next_ptr(read_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                        // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) storage[write_ptr] <= push_data;
  end

endmodule

// File: design/l2_defines.sv
package l2_defines;

  localparam int L2_WAYS        = 2;                    // Two ways, one LRU bit per set
  localparam int WORDS_PER_LINE = 4;                    // 32-bit words per line

  typedef logic [31:0] l2_addr_t;                       // Byte address, low two bits zero
  typedef logic [WORDS_PER_LINE*32-1:0] line_data_t;    // Word 0 in the low bits
  typedef logic [1:0] core_id_t;                        // Up to four cores

  typedef struct packed {
    logic        store;                                 // Word store, else word load
    l2_addr_t    address;
    logic [31:0] data;                                  // Store data
    core_id_t    core;                                  // Stamped by the arbiter
  } l2_request_t;

  typedef struct packed {
    core_id_t    core;                                  // Requesting core
    logic        store;
    l2_addr_t    address;
    logic [31:0] data;                                  // Load data, zero for stores
  } l2_response_t;

  typedef l2_request_t fill_entry_t;                    // Missed request waiting for its line

  typedef struct packed {
    logic       write;                                  // Writeback, else line read
    l2_addr_t   address;                                // Line address
    line_data_t data;                                   // Only for writes
  } mem_request_t;

  typedef struct packed {
    l2_addr_t   address;                                // Line address of the victim
    line_data_t data;
  } writeback_entry_t;

endpackage
